/* fetch_top.f */
rtl/fetch_pkg.sv
rtl/if_stage_1.sv
rtl/icache.sv
rtl/if_stage_2.sv
rtl/fetch_top.sv
tb/fetch_assert.sv
tb/fetch_tb.sv

/* rtl/fetch_pkg.sv */
// --------------------------------------------------
// fetch package
// widths, fetch constants, exception causes and the
// packets passed between the fetch stages and the cache
// --------------------------------------------------
`default_nettype none

package fetch_pkg;

    // datapath widths
    localparam int unsigned XLEN   = 32;
    localparam int unsigned INST_W = 32;

    // cache geometry, direct mapped
    localparam int unsigned LINE_WORDS  = 4;
    localparam int unsigned LINE_W      = LINE_WORDS * INST_W;
    localparam int unsigned ICACHE_SETS = 16;
    localparam int unsigned OFFSET_W    = 4;
    localparam int unsigned INDEX_W     = 4;
    // whatever is left above index and offset
    localparam int unsigned TAG_W       = XLEN - INDEX_W - OFFSET_W;

    // first pc out of reset
    localparam logic [XLEN-1:0] RESET_PC    = 32'h0000_1000;
    // fetches at or above this address fault
    localparam logic [XLEN-1:0] FETCH_LIMIT = 32'h0001_0000;

    // mcause codes raised by fetch
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        INSTR_PAGE_FAULT      = 4'd12
    } exc_cause_t;

    typedef struct packed {
        logic            valid;
        exc_cause_t      cause;
        logic [XLEN-1:0] origin;
    } exception_t;

    // stage one to stage two
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc_inst;
        exception_t      ex;
    } if_1_if_2_stage_t;

    // fetch request into the icache
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] vaddr;
    } req_cpu_icache_t;

    // icache answer, data is zero on a fault
    typedef struct packed {
        logic              valid;
        logic [INST_W-1:0] data;
        logic              instr_page_fault;
    } resp_icache_cpu_t;

    // fetch output towards decode
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc_inst;
        logic [INST_W-1:0] inst;
        exception_t        ex;
    } if_id_stage_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

    // line refill port
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] line_addr;
    } mem_req_t;

    typedef struct packed {
        logic              valid;
        logic [LINE_W-1:0] data;
    } mem_resp_t;

endpackage

`default_nettype wire

/* rtl/fetch_top.sv */
// --------------------------------------------------
// fetch front end
// stage one, icache and stage two wired to decode,
// the redirect strobe and the refill memory port
// --------------------------------------------------
`default_nettype none

module fetch_top
    import fetch_pkg::*;
(
    input  logic         clk_i,
    input  logic         rstn_i,
    // redirect from later in the pipeline
    input  redirect_t    redirect_i,
    // decode back-pressure
    input  logic         id_stall_i,
    // refill port
    input  mem_resp_t    mem_resp_i,
    output mem_req_t     mem_req_o,
    // packet to decode
    output if_id_stage_t fetch_o
);

    req_cpu_icache_t  icache_req;
    resp_icache_cpu_t icache_resp;
    if_1_if_2_stage_t stage_1_pkt;
    logic             miss_stall;
    logic             hold;
    logic             flush;

    // stage one waits on decode and on a pending miss
    assign hold  = id_stall_i || miss_stall;
    // a redirect flushes everything after the pc
    assign flush = redirect_i.valid;

    if_stage_1 if_stage_1_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .redirect_i (redirect_i),
        .stall_i    (hold),
        .req_o      (icache_req),
        .fetch_o    (stage_1_pkt)
    );

    icache icache_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .req_i      (icache_req),
        .flush_i    (flush),
        .resp_o     (icache_resp),
        .mem_req_o  (mem_req_o),
        .mem_resp_i (mem_resp_i)
    );

    // stage two only sees the decode stall for its buffer
    if_stage_2 if_stage_2_inst (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .fetch_i           (stage_1_pkt),
        .resp_icache_cpu_i (icache_resp),
        .stall_i           (id_stall_i),
        .flush_i           (flush),
        .fetch_o           (fetch_o),
        .stall_o           (miss_stall)
    );

endmodule

`default_nettype wire

/* rtl/icache.sv */
// --------------------------------------------------
// instruction cache
// direct mapped and blocking, refills one line per miss
// from the memory port, faults at or above FETCH_LIMIT
// --------------------------------------------------
`default_nettype none

module icache
    import fetch_pkg::*;
(
    input  logic             clk_i,
    input  logic             rstn_i,
    // request from stage one
    input  req_cpu_icache_t  req_i,
    // redirect, drops the pending response
    input  logic             flush_i,
    // response to stage two
    output resp_icache_cpu_t resp_o,
    // line refill port
    output mem_req_t         mem_req_o,
    input  mem_resp_t        mem_resp_i
);

    typedef enum logic [1:0] {
        IDLE,
        REFILL,
        RESPOND
    } state_t;

    state_t                   state_q;
    state_t                   state_d;
    req_cpu_icache_t          req_q;
    req_cpu_icache_t          req_d;
    logic [XLEN-1:0]          refill_addr_q;
    logic [LINE_W-1:0]        line_q;
    logic [ICACHE_SETS-1:0]   valid_q;
    logic [TAG_W-1:0]         tag_q  [ICACHE_SETS];
    logic [LINE_W-1:0]        data_q [ICACHE_SETS];
    logic [INDEX_W-1:0]       req_index;
    logic [TAG_W-1:0]         req_tag;
    logic [OFFSET_W-3:0]      word_sel;
    logic [XLEN-1:0]          req_line;
    logic [INDEX_W-1:0]       refill_index;
    logic                     hit;
    logic                     page_fault;
    logic                     fill_en;

    // split the registered request address
    assign req_index = req_q.vaddr[OFFSET_W +: INDEX_W];
    assign req_tag   = req_q.vaddr[XLEN-1 -: TAG_W];
    assign word_sel  = req_q.vaddr[OFFSET_W-1:2];
    assign req_line  = {req_q.vaddr[XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};

    assign refill_index = refill_addr_q[OFFSET_W +: INDEX_W];

    // tag compare and fetch limit check
    assign hit        = valid_q[req_index] && (tag_q[req_index] == req_tag);
    assign page_fault = (req_q.vaddr >= FETCH_LIMIT);

    // line address always follows the request, the strobe marks it
    assign mem_req_o.line_addr = req_line;

    always_comb begin
        state_d                 = state_q;
        req_d                   = req_q;
        fill_en                 = 1'b0;
        mem_req_o.valid         = 1'b0;
        resp_o.valid            = 1'b0;
        resp_o.data             = '0;
        resp_o.instr_page_fault = 1'b0;
        case (state_q)
            IDLE: begin
                req_d = req_i;
                if (req_q.valid && !flush_i) begin
                    if (page_fault) begin
                        // answered without touching memory
                        resp_o.valid            = 1'b1;
                        resp_o.instr_page_fault = 1'b1;
                    end else if (hit) begin
                        resp_o.valid = 1'b1;
                        resp_o.data  = data_q[req_index][INST_W*word_sel +: INST_W];
                    end else begin
                        // single strobe, keep the request for the answer
                        mem_req_o.valid = 1'b1;
                        req_d           = req_q;
                        state_d         = REFILL;
                    end
                end
            end
            REFILL: begin
                // after a redirect stage one may send a new request meanwhile
                if (flush_i) begin
                    req_d.valid = 1'b0;
                end else if (req_i.valid) begin
                    req_d = req_i;
                end
                if (mem_resp_i.valid) begin
                    fill_en = 1'b1;
                    // answer from the line only if the request still wants it,
                    // otherwise idle looks it up again next cycle
                    if (req_q.valid && !flush_i && !req_i.valid &&
                            (req_line == refill_addr_q)) begin
                        state_d = RESPOND;
                    end else begin
                        state_d = IDLE;
                    end
                end
            end
            RESPOND: begin
                req_d   = req_i;
                state_d = IDLE;
                if (!flush_i) begin
                    resp_o.valid = 1'b1;
                    resp_o.data  = line_q[INST_W*word_sel +: INST_W];
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
            req_q   <= '0;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            req_q   <= req_d;
            if (fill_en) begin
                valid_q[refill_index] <= 1'b1;
            end
        end
    end

    // tag and data arrays, refill address and line copy
    always_ff @(posedge clk_i) begin
        if (mem_req_o.valid) begin
            refill_addr_q <= req_line;
        end
        if (fill_en) begin
            tag_q[refill_index]  <= refill_addr_q[XLEN-1 -: TAG_W];
            data_q[refill_index] <= mem_resp_i.data;
            line_q               <= mem_resp_i.data;
        end
    end

endmodule

`default_nettype wire

/* rtl/if_stage_1.sv */
// --------------------------------------------------
// fetch stage one
// program counter with redirect, misalignment check,
// icache request and the packet register for stage two
// --------------------------------------------------
`default_nettype none

module if_stage_1
    import fetch_pkg::*;
(
    input  logic             clk_i,
    input  logic             rstn_i,
    // redirect strobe from the back end
    input  redirect_t        redirect_i,
    // hold from decode or from a pending miss
    input  logic             stall_i,
    // request for the pc currently held
    output req_cpu_icache_t  req_o,
    // registered packet into stage two
    output if_1_if_2_stage_t fetch_o
);

    logic [XLEN-1:0]  pc_q;
    logic [XLEN-1:0]  pc_d;
    logic             misaligned;
    if_1_if_2_stage_t fetch_q;
    if_1_if_2_stage_t fetch_d;

    // no compressed support, so any of the two low bits set is misaligned
    assign misaligned = (pc_q[1:0] != 2'b00);

    // next pc
    // redirect wins over the hold so a miss can be abandoned
    always_comb begin
        if (redirect_i.valid) begin
            pc_d = redirect_i.target;
        end else if (stall_i) begin
            pc_d = pc_q;
        end else begin
            pc_d = pc_q + XLEN'(4);
        end
    end

    // packet towards stage two
    always_comb begin
        fetch_d = fetch_q;
        if (redirect_i.valid) begin
            // old path is dropped, payload left as is
            fetch_d.valid = 1'b0;
        end else if (!stall_i) begin
            fetch_d.valid     = 1'b1;
            fetch_d.pc_inst   = pc_q;
            fetch_d.ex.valid  = misaligned;
            fetch_d.ex.cause  = INSTR_ADDR_MISALIGNED;
            fetch_d.ex.origin = pc_q;
        end
    end

    // icache request
    // only issued when the packet for this pc is registered on the same edge,
    // never for a misaligned pc and never in a redirect cycle
    assign req_o.valid = !stall_i && !misaligned && !redirect_i.valid;
    assign req_o.vaddr = pc_q;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q    <= RESET_PC;
            fetch_q <= '0;
        end else begin
            pc_q    <= pc_d;
            fetch_q <= fetch_d;
        end
    end

    assign fetch_o = fetch_q;

endmodule

`default_nettype wire

/* rtl/if_stage_2.sv */
// --------------------------------------------------
// fetch stage two
// joins the icache answer with the stage one packet,
// orders exceptions and buffers answers under stall
// --------------------------------------------------
`default_nettype none

module if_stage_2
    import fetch_pkg::*;
(
    input  logic             clk_i,
    input  logic             rstn_i,
    // packet from stage one
    input  if_1_if_2_stage_t fetch_i,
    // answer from the icache
    input  resp_icache_cpu_t resp_icache_cpu_i,
    // decode stall and redirect flush
    input  logic             stall_i,
    input  logic             flush_i,
    // packet towards decode
    output if_id_stage_t     fetch_o,
    // holds stage one while the miss is pending
    output logic             stall_o
);

    resp_icache_cpu_t resp_q;
    resp_icache_cpu_t resp_d;
    logic             resp_avail;
    logic             page_fault;

    // an answer is either live this cycle or parked in the buffer
    assign resp_avail = resp_q.valid || resp_icache_cpu_i.valid;

    // fault flag from whichever answer is present, buffer first
    always_comb begin
        if (resp_q.valid) begin
            page_fault = resp_q.instr_page_fault;
        end else if (resp_icache_cpu_i.valid) begin
            page_fault = resp_icache_cpu_i.instr_page_fault;
        end else begin
            page_fault = 1'b0;
        end
    end

    // exception ordering
    // stage one already carries misalignment, which beats the page fault
    always_comb begin
        if (fetch_i.ex.valid) begin
            fetch_o.ex.valid = 1'b1;
            fetch_o.ex.cause = fetch_i.ex.cause;
        end else if (page_fault) begin
            fetch_o.ex.valid = 1'b1;
            fetch_o.ex.cause = INSTR_PAGE_FAULT;
        end else begin
            fetch_o.ex.valid = 1'b0;
            fetch_o.ex.cause = INSTR_ADDR_MISALIGNED;
        end
    end

    // faulting pc is the packet pc in both cases
    assign fetch_o.ex.origin = fetch_i.pc_inst;
    assign fetch_o.pc_inst   = fetch_i.pc_inst;

    // instruction word, zero when nothing came back
    always_comb begin
        if (resp_q.valid) begin
            fetch_o.inst = resp_q.data;
        end else if (resp_icache_cpu_i.valid) begin
            fetch_o.inst = resp_icache_cpu_i.data;
        end else begin
            fetch_o.inst = '0;
        end
    end

    // valid once the word is here or an exception needs no word,
    // nothing leaves in the redirect cycle itself
    assign fetch_o.valid = fetch_i.valid && !flush_i && (resp_avail || fetch_i.ex.valid);

    // miss pending
    assign stall_o = fetch_i.valid && !(resp_avail || fetch_i.ex.valid);

    // answer buffer
    always_comb begin
        if (flush_i) begin
            resp_d = '0;
        end else if (resp_icache_cpu_i.valid && stall_i) begin
            // decode busy, park the word
            resp_d = resp_icache_cpu_i;
        end else if (resp_q.valid && !stall_i) begin
            // consumed this cycle
            resp_d = '0;
        end else begin
            resp_d = resp_q;
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            resp_q <= '0;
        end else begin
            resp_q <= resp_d;
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the fetch testbench with Verilator and run it
# the exit status of the simulation is the result
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal \
    --top-module fetch_tb -f fetch_top.f -o fetch_sim &&
./obj_dir/fetch_sim || exit 1

/* tb/fetch_assert.sv */
// --------------------------------------------------
// fetch assertions
// refill strobe rules and output hold under stall,
// bound into the fetch front end
// --------------------------------------------------
`default_nettype none

module fetch_assert
    import fetch_pkg::*;
(
    input logic         clk_i,
    input logic         rstn_i,
    input redirect_t    redirect_i,
    input logic         id_stall_i,
    input mem_resp_t    mem_resp_i,
    input mem_req_t     mem_req_i,
    input if_id_stage_t fetch_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // one refill in flight between strobe and answer
    logic refill_pending;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            refill_pending <= 1'b0;
        end else if (mem_req_i.valid) begin
            refill_pending <= 1'b1;
        end else if (mem_resp_i.valid) begin
            refill_pending <= 1'b0;
        end
    end

    // refill request is a single cycle strobe
    refill_strobe_single: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_req_i.valid |=> !mem_req_i.valid)
        else $error("refill strobe held for two cycles");

    refill_one_outstanding: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_req_i.valid |-> !refill_pending)
        else $error("refill strobe before the previous refill was answered");

    // decode sees the same packet until it takes it, unless a redirect kills it
    fetch_hold_stalled: assert property (@(posedge clk_i) disable iff (!rstn_i)
        fetch_i.valid && id_stall_i |=> redirect_i.valid || (fetch_i == $past(fetch_i)))
        else $error("fetch output changed while decode stalled");

endmodule

bind fetch_top fetch_assert fetch_assert_inst (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .redirect_i (redirect_i),
    .id_stall_i (id_stall_i),
    .mem_resp_i (mem_resp_i),
    .mem_req_i  (mem_req_o),
    .fetch_i    (fetch_o)
);

`default_nettype wire

/* tb/fetch_tb.sv */
// --------------------------------------------------
// fetch front end testbench
// random redirects and decode stalls, a line memory
// with random latency and a pc model for every packet
// --------------------------------------------------
`default_nettype none

module fetch_tb
    import fetch_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned RESET_CYCLES    = 16;
    localparam int unsigned NUM_PACKETS     = 3000;
    // generous bound, a miss costs about a dozen cycles
    localparam int unsigned WATCHDOG_CYCLES = NUM_PACKETS * 40;

    logic         clk_i;
    logic         rstn_i;
    redirect_t    redirect_i;
    logic         id_stall_i;
    mem_resp_t    mem_resp_i;
    mem_req_t     mem_req_o;
    if_id_stage_t fetch_o;

    integer             seed;
    // pc of the next packet decode should take
    logic [XLEN-1:0]    exp_pc;
    int unsigned        consumed;
    // memory side, one refill at a time
    logic               refill_busy;
    int unsigned        refill_wait;
    logic [XLEN-1:0]    refill_line;
    // lines the cache must already hold
    logic [XLEN-1:0]    shadow_line [ICACHE_SETS];
    logic [ICACHE_SETS-1:0] shadow_valid;
    // packet seen under stall in the previous cycle
    logic               held_valid;
    if_id_stage_t       held_pkt;
    // earlier redirect targets, reused to get hits
    logic [XLEN-1:0]    recent [8];
    logic [2:0]         recent_idx;

    fetch_top fetch_top_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .redirect_i (redirect_i),
        .id_stall_i (id_stall_i),
        .mem_resp_i (mem_resp_i),
        .mem_req_o  (mem_req_o),
        .fetch_o    (fetch_o)
    );

    always #2 clk_i = ~clk_i;

    // memory contents, odd multiply keeps every address distinct
    function automatic logic [INST_W-1:0] mem_word(input logic [XLEN-1:0] addr);
        logic [31:0] x;
        x = addr * 32'h9e37_79b1;
        x = x ^ (addr >> 11) ^ 32'h5a5a_0f0f;
        return x;
    endfunction

    // word zero sits in the low bits of the line
    function automatic logic [LINE_W-1:0] line_data(input logic [XLEN-1:0] line);
        logic [LINE_W-1:0] data;
        data = '0;
        for (int i = 0; i < LINE_WORDS; i++) begin
            data[INST_W*i +: INST_W] = mem_word(line + XLEN'(4 * i));
        end
        return data;
    endfunction

    function automatic logic [XLEN-1:0] line_of(input logic [XLEN-1:0] addr);
        return {addr[XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};
    endfunction

    // misaligned first, then the fetch limit, then the memory word
    function automatic if_id_stage_t expected_packet(input logic [XLEN-1:0] pc);
        if_id_stage_t pkt;
        pkt.valid     = 1'b1;
        pkt.pc_inst   = pc;
        pkt.inst      = '0;
        pkt.ex.valid  = 1'b1;
        pkt.ex.cause  = INSTR_ADDR_MISALIGNED;
        pkt.ex.origin = pc;
        if (pc[1:0] == 2'b00) begin
            if (pc >= FETCH_LIMIT) begin
                pkt.ex.cause = INSTR_PAGE_FAULT;
            end else begin
                pkt.ex.valid = 1'b0;
                pkt.inst     = mem_word(pc);
            end
        end
        return pkt;
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic compare_fetch(input if_id_stage_t got, input if_id_stage_t exp,
                                 input string name);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic compare_mem_req(input mem_req_t got, input mem_req_t exp,
                                   input string name);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    // a few targets fault, some are misaligned, some revisit old code
    task automatic choose_target(output logic [XLEN-1:0] target);
        logic [31:0] r;
        logic [1:0]  low;
        r   = $random(seed);
        low = (r[17:16] == 2'b00) ? 2'b10 : r[17:16];
        case (r[3:0])
            4'd0: target = FETCH_LIMIT + {18'h0, r[15:4], 2'b00};
            4'd1: target = {18'h0, r[15:4], low};
            4'd2: target = FETCH_LIMIT + {18'h0, r[15:4], low};
            // just below the limit, runs into the fault
            4'd3: target = FETCH_LIMIT - {24'h0, r[9:4], 2'b00};
            4'd4, 4'd5, 4'd6, 4'd7: target = recent[r[6:4]];
            default: target = RESET_PC + {20'h0, r[13:4], 2'b00};
        endcase
        if (r[3:0] == 4'd3 || r[3:0] >= 4'd8) begin
            recent[recent_idx] = target;
            recent_idx         = recent_idx + 3'd1;
        end
    endtask

    // packet must not move while decode stalls
    task automatic watch_hold();
        if (held_valid && !redirect_i.valid) begin
            compare_fetch(fetch_o, held_pkt, "fetch_o under stall");
        end
        held_valid = fetch_o.valid && id_stall_i;
        held_pkt   = fetch_o;
    endtask

    // a strobe always belongs to the packet decode waits for
    task automatic watch_refill();
        mem_req_t           exp_req;
        logic [INDEX_W-1:0] set;
        logic [31:0]        r;
        if (mem_req_o.valid) begin
            exp_req.valid     = 1'b1;
            exp_req.line_addr = line_of(exp_pc);
            compare_mem_req(mem_req_o, exp_req, "mem_req_o");
            set = mem_req_o.line_addr[OFFSET_W +: INDEX_W];
            if (mem_req_o.line_addr >= FETCH_LIMIT) begin
                stop_on_error("refill requested at or above the fetch limit");
            end
            if (shadow_valid[set] && shadow_line[set] == mem_req_o.line_addr) begin
                stop_on_error("refill requested for a line the cache already holds");
            end
            if (refill_busy) begin
                stop_on_error("second refill requested before the first was answered");
            end
            r           = $random(seed);
            refill_busy = 1'b1;
            refill_line = mem_req_o.line_addr;
            refill_wait = 32'd1 + (r % 32'd8);
        end
    endtask

    task automatic follow_fetch();
        if (redirect_i.valid) begin
            exp_pc = redirect_i.target;
        end else if (fetch_o.valid && !id_stall_i) begin
            compare_fetch(fetch_o, expected_packet(exp_pc), "fetch_o");
            exp_pc   = exp_pc + XLEN'(4);
            consumed = consumed + 1;
        end
    endtask

    // answer counts down from the strobe edge
    task automatic answer_refill();
        mem_resp_t          next_resp;
        logic [INDEX_W-1:0] set;
        next_resp = '0;
        set       = refill_line[OFFSET_W +: INDEX_W];
        if (refill_busy) begin
            if (refill_wait == 0) begin
                next_resp.valid   = 1'b1;
                next_resp.data    = line_data(refill_line);
                // line is written even if a redirect drops the answer
                shadow_valid[set] = 1'b1;
                shadow_line[set]  = refill_line;
                refill_busy       = 1'b0;
            end else begin
                refill_wait = refill_wait - 1;
            end
        end
        mem_resp_i <= next_resp;
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        redirect_t   next_redirect;
        r             = $random(seed);
        next_redirect = '0;
        // stall about one cycle in four
        id_stall_i <= (r[1:0] == 2'b00);
        r = $random(seed);
        if ((r % 32'd40) == 32'd0) begin
            next_redirect.valid = 1'b1;
            choose_target(next_redirect.target);
        end
        redirect_i <= next_redirect;
    endtask

    always @(posedge clk_i) begin
        if (rstn_i) begin
            watch_hold();
            watch_refill();
            follow_fetch();
            answer_refill();
            drive_inputs();
        end
    end

    initial begin
        seed         = 32'ha2d0_f1d0;
        exp_pc       = RESET_PC;
        consumed     = 0;
        refill_busy  = 1'b0;
        refill_wait  = 0;
        refill_line  = '0;
        shadow_valid = '0;
        held_valid   = 1'b0;
        held_pkt     = '0;
        recent_idx   = 3'd0;
        for (int i = 0; i < 8; i++) begin
            recent[i] = RESET_PC;
        end
        clk_i      = 1'b0;
        rstn_i     = 1'b0;
        redirect_i = '0;
        id_stall_i = 1'b0;
        mem_resp_i = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rstn_i <= 1'b1;
    end

    initial begin
        wait (consumed == NUM_PACKETS);
        $display("Testbench passed");
        $finish;
    end

    // watchdog
    initial begin
        repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clk_i);
        stop_on_error("timeout, not all packets were consumed in time");
    end

endmodule

`default_nettype wire
